//--- Bender.yml
package:
  name: mem_island

sources:
  - mem_island_pkg.sv
  - sram_bank.sv
  - bank_arbiter.sv
  - narrow_router.sv
  - wide_splitter.sv
  - mem_island_top.sv
  - target: simulation
    files:
      - tb_mem_island.sv

//--- bank_arbiter.sv
// Narrow/wide arbitration in front of one SRAM bank.
// Narrow has priority; after WidePriorityWait contended cycles the wide
// port gets one cycle. WidePriorityWait = 0 lets narrow win always.
`timescale 1ns/10ps

module bank_arbiter #(
  parameter int unsigned WidePriorityWait = 2
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         narrow_req_i,
  input  logic                         narrow_we_i,
  input  mem_island_pkg::row_t         narrow_row_i,
  input  mem_island_pkg::narrow_data_t narrow_wdata_i,
  input  mem_island_pkg::narrow_strb_t narrow_strb_i,
  output logic                         narrow_gnt_o,
  input  logic                         wide_req_i,
  input  logic                         wide_go_i,
  input  logic                         wide_we_i,
  input  mem_island_pkg::row_t         wide_row_i,
  input  mem_island_pkg::narrow_data_t wide_wdata_i,
  input  mem_island_pkg::narrow_strb_t wide_strb_i,
  output logic                         wide_allow_o,
  output mem_island_pkg::narrow_data_t rdata_o
);

  localparam int unsigned CntWidth =
      (WidePriorityWait > 0) ? $clog2(WidePriorityWait + 1) : 1;

  logic [CntWidth-1:0] wait_q;
  logic [CntWidth-1:0] wait_d;
  logic wide_turn;
  logic narrow_win;

  logic                         bank_req;
  logic                         bank_we;
  mem_island_pkg::row_t         bank_row;
  mem_island_pkg::narrow_data_t bank_wdata;
  mem_island_pkg::narrow_strb_t bank_strb;

  assign wide_turn  = (WidePriorityWait != 0) && (wait_q == CntWidth'(WidePriorityWait));
  assign narrow_win = narrow_req_i && !wide_turn;

  // Count consecutive cycles where wide waits behind narrow
  always_comb begin
    wait_d = '0;
    if ((WidePriorityWait != 0) && narrow_win && wide_req_i) begin
      wait_d = wait_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wait_q <= '0;
    end else begin
      wait_q <= wait_d;
    end
  end

  assign narrow_gnt_o = narrow_win;
  assign wide_allow_o = !narrow_win;

  assign bank_req   = narrow_win || wide_go_i;
  assign bank_we    = wide_go_i ? wide_we_i    : narrow_we_i;
  assign bank_row   = wide_go_i ? wide_row_i   : narrow_row_i;
  assign bank_wdata = wide_go_i ? wide_wdata_i : narrow_wdata_i;
  assign bank_strb  = wide_go_i ? wide_strb_i  : narrow_strb_i;

  sram_bank i_sram_bank (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (bank_req),
    .we_i    (bank_we),
    .addr_i  (bank_row),
    .wdata_i (bank_wdata),
    .be_i    (bank_strb),
    .rdata_o (rdata_o)
  );

  // The splitter must only fire when every sub-bank, this one included, allows it
  assert property (@(posedge clk_i) disable iff (!rst_ni) !(narrow_gnt_o && wide_go_i))
    else $error("narrow grant and wide access on the same bank");

endmodule

//--- filelist.f
mem_island_pkg.sv
sram_bank.sv
bank_arbiter.sv
narrow_router.sv
wide_splitter.sv
mem_island_top.sv
tb_mem_island.sv

//--- mem_island_pkg.sv
// Shared widths, address map and payload types of the banked scratchpad.
// Every design file refers to these by scoped name.
package mem_island_pkg;

  // Port widths
  localparam int unsigned AddrWidth       = 8;
  localparam int unsigned NarrowDataWidth = 32;
  localparam int unsigned WideDataWidth   = 64;

  // Banking
  localparam int unsigned NumSubBanks  = WideDataWidth / NarrowDataWidth;
  localparam int unsigned NumWideBanks = 2;
  localparam int unsigned NumBanks     = NumWideBanks * NumSubBanks;
  localparam int unsigned WordsPerBank = 16;

  // Byte address map: row | wide bank | sub-bank | byte offset
  localparam int unsigned SubBankBit  = 2;
  localparam int unsigned WideBankBit = 3;
  localparam int unsigned RowLsb      = 4;

  typedef logic [NarrowDataWidth-1:0]   narrow_data_t;
  typedef logic [NarrowDataWidth/8-1:0] narrow_strb_t;
  typedef logic [WideDataWidth-1:0]     wide_data_t;
  typedef logic [WideDataWidth/8-1:0]   wide_strb_t;

  typedef logic [AddrWidth-1:0]             addr_t;
  typedef logic [$clog2(WordsPerBank)-1:0]  row_t;
  // Bank number is wide bank * NumSubBanks + sub-bank
  typedef logic [$clog2(NumBanks)-1:0]      bank_idx_t;

endpackage

//--- mem_island_top.sv
// Top level of the scratchpad: one narrow and one wide port over
// two wide banks of two 32-bit sub-banks each.
// WidePriorityWait sets how long the wide port waits behind narrow traffic.
`timescale 1ns/10ps

module mem_island_top #(
  parameter int unsigned WidePriorityWait = 2
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         narrow_req_i,
  output logic                         narrow_gnt_o,
  input  mem_island_pkg::addr_t        narrow_addr_i,
  input  logic                         narrow_we_i,
  input  mem_island_pkg::narrow_data_t narrow_wdata_i,
  input  mem_island_pkg::narrow_strb_t narrow_strb_i,
  output logic                         narrow_rvalid_o,
  output mem_island_pkg::narrow_data_t narrow_rdata_o,
  input  logic                         wide_req_i,
  output logic                         wide_gnt_o,
  input  mem_island_pkg::addr_t        wide_addr_i,
  input  logic                         wide_we_i,
  input  mem_island_pkg::wide_data_t   wide_wdata_i,
  input  mem_island_pkg::wide_strb_t   wide_strb_i,
  output logic                         wide_rvalid_o,
  output mem_island_pkg::wide_data_t   wide_rdata_o
);

  localparam int unsigned NumWideBanks = mem_island_pkg::NumWideBanks;
  localparam int unsigned NumSubBanks  = mem_island_pkg::NumSubBanks;
  localparam int unsigned NumBanks     = mem_island_pkg::NumBanks;

  // Narrow side, shared payload and one request per bank
  logic [NumBanks-1:0]                         nb_req;
  logic [NumBanks-1:0]                         nb_gnt;
  mem_island_pkg::row_t                        nb_row;
  logic                                        nb_we;
  mem_island_pkg::narrow_data_t                nb_wdata;
  mem_island_pkg::narrow_strb_t                nb_strb;
  mem_island_pkg::narrow_data_t [NumBanks-1:0] bank_rdata;

  // Wide side, per wide bank
  mem_island_pkg::row_t                                          wide_row;
  logic [NumWideBanks-1:0][NumSubBanks-1:0]                      wb_req;
  logic [NumWideBanks-1:0][NumSubBanks-1:0]                      wb_allow;
  logic [NumWideBanks-1:0][NumSubBanks-1:0]                      wb_go;
  mem_island_pkg::narrow_data_t [NumWideBanks-1:0][NumSubBanks-1:0] wb_wdata;
  mem_island_pkg::narrow_strb_t [NumWideBanks-1:0][NumSubBanks-1:0] wb_strb;
  logic [NumWideBanks-1:0]                                       wb_we;
  mem_island_pkg::row_t [NumWideBanks-1:0]                       wb_row;
  logic [NumWideBanks-1:0]                                       split_gnt;
  logic [NumWideBanks-1:0]                                       split_rvalid;
  mem_island_pkg::wide_data_t [NumWideBanks-1:0]                 split_rdata;

  assign wide_row = wide_addr_i[mem_island_pkg::RowLsb +: $bits(mem_island_pkg::row_t)];

  narrow_router i_narrow_router (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (narrow_req_i),
    .addr_i       (narrow_addr_i),
    .we_i         (narrow_we_i),
    .wdata_i      (narrow_wdata_i),
    .strb_i       (narrow_strb_i),
    .gnt_o        (narrow_gnt_o),
    .rvalid_o     (narrow_rvalid_o),
    .rdata_o      (narrow_rdata_o),
    .bank_req_o   (nb_req),
    .bank_row_o   (nb_row),
    .bank_we_o    (nb_we),
    .bank_wdata_o (nb_wdata),
    .bank_strb_o  (nb_strb),
    .bank_gnt_i   (nb_gnt),
    .bank_rdata_i (bank_rdata)
  );

  for (genvar w = 0; w < NumWideBanks; w++) begin : gen_wide_bank
    wide_splitter i_wide_splitter (
      .clk_i        (clk_i),
      .rst_ni       (rst_ni),
      .req_i        (wide_req_i && (wide_addr_i[mem_island_pkg::WideBankBit] == 1'(w))),
      .we_i         (wide_we_i),
      .row_i        (wide_row),
      .wdata_i      (wide_wdata_i),
      .strb_i       (wide_strb_i),
      .gnt_o        (split_gnt[w]),
      .rvalid_o     (split_rvalid[w]),
      .rdata_o      (split_rdata[w]),
      .bank_req_o   (wb_req[w]),
      .bank_allow_i (wb_allow[w]),
      .bank_go_o    (wb_go[w]),
      .bank_we_o    (wb_we[w]),
      .bank_row_o   (wb_row[w]),
      .bank_wdata_o (wb_wdata[w]),
      .bank_strb_o  (wb_strb[w]),
      .bank_rdata_i (bank_rdata[w*NumSubBanks +: NumSubBanks])
    );

    for (genvar s = 0; s < NumSubBanks; s++) begin : gen_sub_bank
      localparam int unsigned BankIdx = w * NumSubBanks + s;

      bank_arbiter #(
        .WidePriorityWait (WidePriorityWait)
      ) i_bank_arbiter (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .narrow_req_i   (nb_req[BankIdx]),
        .narrow_we_i    (nb_we),
        .narrow_row_i   (nb_row),
        .narrow_wdata_i (nb_wdata),
        .narrow_strb_i  (nb_strb),
        .narrow_gnt_o   (nb_gnt[BankIdx]),
        .wide_req_i     (wb_req[w][s]),
        .wide_go_i      (wb_go[w][s]),
        .wide_we_i      (wb_we[w]),
        .wide_row_i     (wb_row[w]),
        .wide_wdata_i   (wb_wdata[w][s]),
        .wide_strb_i    (wb_strb[w][s]),
        .wide_allow_o   (wb_allow[w][s]),
        .rdata_o        (bank_rdata[BankIdx])
      );
    end
  end

  // At most one splitter is active, idle ones drive zero
  always_comb begin
    wide_gnt_o    = 1'b0;
    wide_rvalid_o = 1'b0;
    wide_rdata_o  = '0;
    for (int w = 0; w < NumWideBanks; w++) begin
      wide_gnt_o    = wide_gnt_o | split_gnt[w];
      wide_rvalid_o = wide_rvalid_o | split_rvalid[w];
      wide_rdata_o  = wide_rdata_o | split_rdata[w];
    end
  end

endmodule

//--- narrow_router.sv
// Routes the narrow port to exactly one bank by address bits.
// The bank index is registered on grant to pick the response word.
`timescale 1ns/10ps

module narrow_router (
  input  logic                                                  clk_i,
  input  logic                                                  rst_ni,
  input  logic                                                  req_i,
  input  mem_island_pkg::addr_t                                 addr_i,
  input  logic                                                  we_i,
  input  mem_island_pkg::narrow_data_t                          wdata_i,
  input  mem_island_pkg::narrow_strb_t                          strb_i,
  output logic                                                  gnt_o,
  output logic                                                  rvalid_o,
  output mem_island_pkg::narrow_data_t                          rdata_o,
  output logic [mem_island_pkg::NumBanks-1:0]                   bank_req_o,
  output mem_island_pkg::row_t                                  bank_row_o,
  output logic                                                  bank_we_o,
  output mem_island_pkg::narrow_data_t                          bank_wdata_o,
  output mem_island_pkg::narrow_strb_t                          bank_strb_o,
  input  logic [mem_island_pkg::NumBanks-1:0]                   bank_gnt_i,
  input  mem_island_pkg::narrow_data_t [mem_island_pkg::NumBanks-1:0] bank_rdata_i
);

  mem_island_pkg::bank_idx_t bank_idx;
  mem_island_pkg::bank_idx_t sel_q;
  logic                      rvalid_q;

  assign bank_idx = {addr_i[mem_island_pkg::WideBankBit], addr_i[mem_island_pkg::SubBankBit]};

  always_comb begin
    for (int b = 0; b < mem_island_pkg::NumBanks; b++) begin
      bank_req_o[b] = req_i && (bank_idx == b);
    end
  end

  assign bank_row_o   = addr_i[mem_island_pkg::RowLsb +: $bits(mem_island_pkg::row_t)];
  assign bank_we_o    = we_i;
  assign bank_wdata_o = wdata_i;
  assign bank_strb_o  = strb_i;

  // Only the addressed bank sees a request, so its grant is ours
  assign gnt_o = bank_gnt_i[bank_idx];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
      sel_q    <= '0;
    end else begin
      rvalid_q <= gnt_o;
      if (gnt_o) begin
        sel_q <= bank_idx;
      end
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = bank_rdata_i[sel_q];

  assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(bank_req_o))
    else $error("narrow request routed to more than one bank");

endmodule

//--- sram_bank.sv
// Single-port SRAM bank, one narrow word wide, with byte strobes.
// Read data appears one cycle after the request and holds until the next read.
`timescale 1ns/10ps

module sram_bank (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         req_i,
  input  logic                         we_i,
  input  mem_island_pkg::row_t         addr_i,
  input  mem_island_pkg::narrow_data_t wdata_i,
  input  mem_island_pkg::narrow_strb_t be_i,
  output mem_island_pkg::narrow_data_t rdata_o
);

  localparam int unsigned NumBytes = $bits(mem_island_pkg::narrow_strb_t);

  mem_island_pkg::narrow_data_t mem_q [mem_island_pkg::WordsPerBank];
  mem_island_pkg::narrow_data_t rdata_q;

  // Byte lanes written only where the strobe is set
  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      for (int i = 0; i < NumBytes; i++) begin
        if (be_i[i]) begin
          mem_q[addr_i][8*i +: 8] <= wdata_i[8*i +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (req_i && !we_i) begin
      rdata_q <= mem_q[addr_i];
    end
  end

  assign rdata_o = rdata_q;

endmodule

//--- tb_mem_island.sv
// Directed testbench for the banked scratchpad.
// A reference memory per bank and row follows every granted write, and each
// response is checked against it one cycle after its grant.
`timescale 1ns/10ps

module tb_mem_island;

  typedef mem_island_pkg::addr_t        addr_t;
  typedef mem_island_pkg::narrow_data_t narrow_data_t;
  typedef mem_island_pkg::narrow_strb_t narrow_strb_t;
  typedef mem_island_pkg::wide_data_t   wide_data_t;
  typedef mem_island_pkg::wide_strb_t   wide_strb_t;

  localparam int unsigned MaxCycles = 3000;

  logic         clk_i;
  logic         rst_ni;
  logic         narrow_req;
  logic         narrow_we;
  addr_t        narrow_addr;
  narrow_data_t narrow_wdata;
  narrow_strb_t narrow_strb;
  logic         narrow_gnt;
  logic         narrow_rvalid;
  narrow_data_t narrow_rdata;
  logic         wide_req;
  logic         wide_we;
  addr_t        wide_addr;
  wide_data_t   wide_wdata;
  wide_strb_t   wide_strb;
  logic         wide_gnt;
  logic         wide_rvalid;
  wide_data_t   wide_rdata;

  narrow_data_t model_mem [mem_island_pkg::NumBanks][mem_island_pkg::WordsPerBank];
  logic         exp_n_valid;
  logic         exp_n_read;
  logic         exp_w_valid;
  logic         exp_w_read;
  narrow_data_t exp_n_data;
  wide_data_t   exp_w_data;
  int unsigned  cycle_count = 0;

  mem_island_top #(
    .WidePriorityWait (2)
  ) UUT (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .narrow_req_i    (narrow_req),
    .narrow_gnt_o    (narrow_gnt),
    .narrow_addr_i   (narrow_addr),
    .narrow_we_i     (narrow_we),
    .narrow_wdata_i  (narrow_wdata),
    .narrow_strb_i   (narrow_strb),
    .narrow_rvalid_o (narrow_rvalid),
    .narrow_rdata_o  (narrow_rdata),
    .wide_req_i      (wide_req),
    .wide_gnt_o      (wide_gnt),
    .wide_addr_i     (wide_addr),
    .wide_we_i       (wide_we),
    .wide_wdata_i    (wide_wdata),
    .wide_strb_i     (wide_strb),
    .wide_rvalid_o   (wide_rvalid),
    .wide_rdata_o    (wide_rdata)
  );

  always #4 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == MaxCycles) begin
      run_error("Timeout, the tests did not finish within the cycle limit");
    end
  end

  task automatic end_with_failure();
    $display("Testbench failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic value_error(string name, logic [63:0] exp_val, logic [63:0] got_val);
    $display("Error at %0t: %s expected 'h%0h, got 'h%0h", $time, name, exp_val, got_val);
    end_with_failure();
  endtask

  task automatic run_error(string what);
    $display("%s (at %0t)", what, $time);
    end_with_failure();
  endtask

  // Address map: row | wide bank | sub-bank | byte offset
  function automatic addr_t make_addr(int unsigned wbank, int unsigned sub, int unsigned row);
    return addr_t'((row << mem_island_pkg::RowLsb) | (wbank << mem_island_pkg::WideBankBit) |
                   (sub << mem_island_pkg::SubBankBit));
  endfunction

  function automatic narrow_data_t merge_bytes(narrow_data_t old_w, narrow_data_t new_w,
                                               narrow_strb_t strb);
    narrow_data_t res;
    res = old_w;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) res[8*i +: 8] = new_w[8*i +: 8];
    end
    return res;
  endfunction

  // Called once per cycle at the falling edge, where all DUT outputs are settled
  task automatic observe();
    int unsigned nb;
    int unsigned nr;
    int unsigned wb;
    int unsigned wr;
    assert (narrow_rvalid === exp_n_valid)
      else value_error("narrow_rvalid_o", exp_n_valid, narrow_rvalid);
    assert (wide_rvalid === exp_w_valid)
      else value_error("wide_rvalid_o", exp_w_valid, wide_rvalid);
    if (exp_n_valid && exp_n_read) begin
      assert (narrow_rdata === exp_n_data)
        else value_error("narrow_rdata_o", exp_n_data, narrow_rdata);
    end
    if (exp_w_valid && exp_w_read) begin
      assert (wide_rdata === exp_w_data)
        else value_error("wide_rdata_o", exp_w_data, wide_rdata);
    end
    nb = 2 * narrow_addr[mem_island_pkg::WideBankBit] + narrow_addr[mem_island_pkg::SubBankBit];
    nr = narrow_addr >> mem_island_pkg::RowLsb;
    wb = 2 * wide_addr[mem_island_pkg::WideBankBit];
    wr = wide_addr >> mem_island_pkg::RowLsb;
    // Read data is taken before this cycle's writes land
    exp_n_valid = narrow_gnt;
    exp_n_read  = !narrow_we;
    exp_n_data  = model_mem[nb][nr];
    exp_w_valid = wide_gnt;
    exp_w_read  = !wide_we;
    exp_w_data  = {model_mem[wb+1][wr], model_mem[wb][wr]};
    if (narrow_gnt && narrow_we) begin
      model_mem[nb][nr] = merge_bytes(model_mem[nb][nr], narrow_wdata, narrow_strb);
    end
    if (wide_gnt && wide_we) begin
      for (int s = 0; s < 2; s++) begin
        model_mem[wb+s][wr] = merge_bytes(model_mem[wb+s][wr], wide_wdata[32*s +: 32],
                                          wide_strb[4*s +: 4]);
      end
    end
  endtask

  task automatic issue_narrow(logic we, addr_t addr, narrow_data_t wdata, narrow_strb_t strb);
    narrow_req   <= 1'b1;
    narrow_we    <= we;
    narrow_addr  <= addr;
    narrow_wdata <= wdata;
    narrow_strb  <= strb;
  endtask

  task automatic issue_wide(logic we, addr_t addr, wide_data_t wdata, wide_strb_t strb);
    wide_req   <= 1'b1;
    wide_we    <= we;
    wide_addr  <= addr;
    wide_wdata <= wdata;
    wide_strb  <= strb;
  endtask

  // Holds each request until granted, then one idle cycle for the last response
  task automatic run_access(logic do_n, logic do_w, output int unsigned cycles);
    logic n_open;
    logic w_open;
    n_open = do_n;
    w_open = do_w;
    cycles = 0;
    while (n_open || w_open) begin
      @(negedge clk_i);
      observe();
      cycles++;
      if (narrow_gnt) n_open = 1'b0;
      if (wide_gnt) w_open = 1'b0;
      @(posedge clk_i);
      if (!n_open) narrow_req <= 1'b0;
      if (!w_open) wide_req <= 1'b0;
    end
    @(negedge clk_i);
    observe();
  endtask

  task automatic narrow_access(logic we, addr_t addr, narrow_data_t wdata, narrow_strb_t strb);
    int unsigned cycles;
    @(posedge clk_i);
    issue_narrow(we, addr, wdata, strb);
    run_access(1'b1, 1'b0, cycles);
  endtask

  task automatic wide_access(logic we, addr_t addr, wide_data_t wdata, wide_strb_t strb);
    int unsigned cycles;
    @(posedge clk_i);
    issue_wide(we, addr, wdata, strb);
    run_access(1'b0, 1'b1, cycles);
  endtask

  task automatic preload_memory();
    for (int w = 0; w < 2; w++) begin
      for (int r = 0; r < 16; r++) begin
        wide_access(1'b1, make_addr(w, 0, r), {$urandom, $urandom}, 8'hff);
      end
    end
  endtask

  task automatic narrow_write_then_read();
    addr_t addr;
    repeat (4) begin
      addr = make_addr($urandom_range(1), $urandom_range(1), $urandom_range(15));
      narrow_access(1'b1, addr, $urandom, narrow_strb_t'($urandom));
      narrow_access(1'b0, addr, '0, '0);
    end
  endtask

  // Offset 0 reads sub-bank 0 (low half), offset 4 sub-bank 1 (high half)
  task automatic wide_write_narrow_read();
    addr_t addr;
    repeat (3) begin
      addr = make_addr($urandom_range(1), 0, $urandom_range(15));
      wide_access(1'b1, addr, {$urandom, $urandom}, 8'hff);
      narrow_access(1'b0, addr, '0, '0);
      narrow_access(1'b0, addr + 8'd4, '0, '0);
    end
  endtask

  task automatic strobed_writes_wide_read();
    addr_t addr;
    repeat (3) begin
      addr = make_addr($urandom_range(1), 0, $urandom_range(15));
      narrow_access(1'b1, addr, $urandom, narrow_strb_t'($urandom_range(14, 1)));
      narrow_access(1'b1, addr + 8'd4, $urandom, narrow_strb_t'($urandom_range(14, 1)));
      wide_access(1'b0, addr, '0, '0);
    end
  endtask

  task automatic parallel_bank_access();
    int unsigned cycles;
    for (int w = 0; w < 2; w++) begin
      for (int we = 0; we < 2; we++) begin
        @(posedge clk_i);
        issue_narrow(we, make_addr(w, $urandom_range(1), $urandom_range(15)), $urandom,
                     narrow_strb_t'($urandom));
        issue_wide(!we, make_addr(1 - w, 0, $urandom_range(15)), {$urandom, $urandom},
                   wide_strb_t'($urandom));
        run_access(1'b1, 1'b1, cycles);
        assert (cycles == 1)
          else run_error("Ports on different wide banks were not granted in the same cycle");
      end
    end
  endtask

  // Narrow wins two contended cycles, then the wide port gets one
  task automatic contended_bank_access();
    logic n_won;
    logic w_won;
    @(posedge clk_i);
    issue_narrow($urandom_range(1), make_addr(0, 1, $urandom_range(15)), $urandom, 4'hf);
    issue_wide($urandom_range(1), make_addr(0, 0, $urandom_range(15)), {$urandom, $urandom},
               8'hff);
    for (int k = 0; k < 12; k++) begin
      @(negedge clk_i);
      observe();
      n_won = narrow_gnt;
      w_won = wide_gnt;
      assert (n_won === (k % 3 != 2)) else value_error("narrow_gnt_o", k % 3 != 2, n_won);
      assert (w_won === (k % 3 == 2)) else value_error("wide_gnt_o", k % 3 == 2, w_won);
      @(posedge clk_i);
      if (n_won) begin
        issue_narrow($urandom_range(1), make_addr(0, 1, $urandom_range(15)), $urandom,
                     narrow_strb_t'($urandom));
      end
      if (w_won) begin
        issue_wide($urandom_range(1), make_addr(0, 0, $urandom_range(15)),
                   {$urandom, $urandom}, wide_strb_t'($urandom));
      end
    end
    narrow_req <= 1'b0;
    wide_req   <= 1'b0;
    @(negedge clk_i);
    observe();
  endtask

  initial begin
    void'($urandom(32'h895f_d7d7));
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    narrow_req   = 1'b0;
    narrow_we    = 1'b0;
    narrow_addr  = '0;
    narrow_wdata = '0;
    narrow_strb  = '0;
    wide_req     = 1'b0;
    wide_we      = 1'b0;
    wide_addr    = '0;
    wide_wdata   = '0;
    wide_strb    = '0;
    exp_n_valid  = 1'b0;
    exp_n_read   = 1'b0;
    exp_w_valid  = 1'b0;
    exp_w_read   = 1'b0;
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    assert (narrow_rvalid === 1'b0 && wide_rvalid === 1'b0)
      else run_error("A response strobe was set right after reset");
    preload_memory();
    narrow_write_then_read();
    wide_write_narrow_read();
    strobed_writes_wide_read();
    parallel_bank_access();
    contended_bank_access();
    $display("Testbench passed");
    $finish;
  end

endmodule

//--- wide_splitter.sv
// Splits one wide access across the sub-banks of a wide bank.
// All sub-banks are taken in the same cycle or none; rdata is zero
// outside rvalid so the top level can OR the splitters together.
`timescale 1ns/10ps

module wide_splitter (
  input  logic                                                     clk_i,
  input  logic                                                     rst_ni,
  input  logic                                                     req_i,
  input  logic                                                     we_i,
  input  mem_island_pkg::row_t                                     row_i,
  input  mem_island_pkg::wide_data_t                               wdata_i,
  input  mem_island_pkg::wide_strb_t                               strb_i,
  output logic                                                     gnt_o,
  output logic                                                     rvalid_o,
  output mem_island_pkg::wide_data_t                               rdata_o,
  output logic [mem_island_pkg::NumSubBanks-1:0]                   bank_req_o,
  input  logic [mem_island_pkg::NumSubBanks-1:0]                   bank_allow_i,
  output logic [mem_island_pkg::NumSubBanks-1:0]                   bank_go_o,
  output logic                                                     bank_we_o,
  output mem_island_pkg::row_t                                     bank_row_o,
  output mem_island_pkg::narrow_data_t [mem_island_pkg::NumSubBanks-1:0] bank_wdata_o,
  output mem_island_pkg::narrow_strb_t [mem_island_pkg::NumSubBanks-1:0] bank_strb_o,
  input  mem_island_pkg::narrow_data_t [mem_island_pkg::NumSubBanks-1:0] bank_rdata_i
);

  localparam int unsigned HalfWidth = $bits(mem_island_pkg::narrow_data_t);
  localparam int unsigned HalfStrb  = $bits(mem_island_pkg::narrow_strb_t);

  logic                       grant;
  logic                       rvalid_q;
  mem_island_pkg::wide_data_t joined;

  // All-or-nothing grant
  assign grant = req_i && (&bank_allow_i);

  assign gnt_o      = grant;
  assign bank_we_o  = we_i;
  assign bank_row_o = row_i;

  always_comb begin
    for (int s = 0; s < mem_island_pkg::NumSubBanks; s++) begin
      bank_req_o[s]   = req_i;
      bank_go_o[s]    = grant;
      // Sub-bank 0 holds the low half
      bank_wdata_o[s] = wdata_i[s*HalfWidth +: HalfWidth];
      bank_strb_o[s]  = strb_i[s*HalfStrb +: HalfStrb];
      joined[s*HalfWidth +: HalfWidth] = bank_rdata_i[s];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= grant;
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rvalid_q ? joined : '0;

  assert property (@(posedge clk_i) disable iff (!rst_ni) gnt_o |=> rvalid_o)
    else $error("wide response missing one cycle after grant");

endmodule
